//--- Makefile
SIM        = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
TOP        = tb_board
FILELIST   = tb.f
BUILD      = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation failed"; exit 1)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

//--- board_config.svh
`ifndef BOARD_CONFIG_SVH
`define BOARD_CONFIG_SVH

// ***********************************************************************
// board clock and divisors, simulation values
// ***********************************************************************

`define CLK_MHZ      10     // system clock in MHz

// cycles per slow strobe
// on the board this is CLK_MHZ * 1000000 for one strobe per second
`define SLOW_DIV     16

`define REFRESH_DIV  4      // cycles per digit scan step

// ***********************************************************************
// display
// ***********************************************************************

`define W_DIGIT      4      // seven-segment digits on the board

`endif

//--- board_pkg.sv
`default_nettype none

`include "board_config.svh"

package board_pkg;

    // ***********************************************************************
    // conditioned board inputs, active high after sync
    // ***********************************************************************

    typedef struct packed {
        logic step;                     // step button
        logic spare;                    // second key, free for other labs
    } key_t;

    typedef struct packed {
        logic [1:0] step_sel;           // step size is 1 << step_sel
        logic       auto_run;           // let the slow strobe step the counter
        logic       down;               // count downward
    } sw_t;

    // ***********************************************************************
    // display drive
    // ***********************************************************************

    // segment a sits in the msb, h is the decimal point
    typedef struct packed {
        logic a;
        logic b;
        logic c;
        logic d;
        logic e;
        logic f;
        logic g;
        logic h;
    } seg_t;

    typedef struct packed {
        seg_t                 seg;      // active high pattern
        logic [`W_DIGIT-1:0]  digit;    // one-hot digit enable
    } disp_t;

endpackage

`default_nettype wire

//--- board_specific_top.sv
`default_nettype none

`include "board_config.svh"

module board_specific_top
    import board_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,

    input  logic [$bits(key_t)-1:0] KEY,        // active low
    input  logic [$bits(sw_t)-1:0]  SW,         // active low

    output logic [3:0]            LED,          // active low
    output logic [$bits(seg_t)-1:0] HGFEDCBA,
    output logic [`W_DIGIT-1:0]   DIGIT
);

    key_t        key;
    sw_t         sw;
    logic        slow_tick;
    logic [15:0] count;
    logic [3:0]  led;
    disp_t       disp;

    // ***********************************************************************
    // input conditioning
    // ***********************************************************************

    input_sync #(.data_t(key_t)) i_key_sync
    (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .pins  ( key_t'(KEY) ),
        .level ( key        )
    );

    input_sync #(.data_t(sw_t)) i_sw_sync
    (
        .clk   ( clk        ),
        .rst_n ( rst_n      ),
        .pins  ( sw_t'(SW)  ),
        .level ( sw         )
    );

    // ***********************************************************************
    // lab blocks
    // ***********************************************************************

    slow_strobe_gen #(.DIV(`SLOW_DIV)) i_slow_strobe_gen
    (
        .clk   ( clk       ),
        .rst_n ( rst_n     ),
        .tick  ( slow_tick )
    );

    hex_counter_lab i_lab
    (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .key       ( key       ),
        .sw        ( sw        ),
        .slow_tick ( slow_tick ),
        .count     ( count     ),
        .led       ( led       )
    );

    seven_seg_mux i_seven_seg_mux
    (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .value ( count ),
        .disp  ( disp  )
    );

    // ***********************************************************************
    // board polarity and segment order
    // ***********************************************************************

    assign LED   = ~led;            // board LEDs light on low
    assign DIGIT = disp.digit;

    // bit 0 of the bus drives segment a
    for (genvar i = 0; i < $bits(seg_t); i++)
    begin : g_seg_rev
        assign HGFEDCBA[i] = disp.seg[$bits(seg_t) - 1 - i];
    end

endmodule

`default_nettype wire

//--- board_stim.txt
# op sw count n   op: P press, A auto run for n LED changes, D display check
# sw is the active high sw_t value in hex, count is the expected count in hex
D 0 0000 0
P 0 0001 0
P 4 0003 0
P 8 0007 0
P C 000F 0
P 0 0010 0
D 0 0010 0
P 1 000F 0
P D 0007 0
P 9 0003 0
P 5 0001 0
P 1 0000 0
P 5 FFFE 0
D 0 FFFE 0
A 2 0001 3
A 7 FFFD 2
D 0 FFFD 0

//--- hex_counter_lab.sv
`default_nettype none

// lab core: 16-bit hex up/down counter
// a button press or a slow strobe (with auto_run) moves it by one step
module hex_counter_lab
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  key_t        key,
    input  sw_t         sw,
    input  logic        slow_tick,
    output logic [15:0] count,
    output logic [3:0]  led
);

    // ***********************************************************************
    // press detection
    // ***********************************************************************

    logic step_d;       // key.step one cycle ago
    logic press;        // registered rising edge of the step key

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            step_d <= 1'b0;
            press  <= 1'b0;
        end
        else
        begin
            step_d <= key.step;
            press  <= key.step & ~step_d;
        end
    end

    // ***********************************************************************
    // step counter
    // ***********************************************************************

    logic        step;
    logic [15:0] delta;

    // a press and a strobe in the same cycle give a single step
    assign step  = press | (slow_tick & sw.auto_run);
    assign delta = 16'(1) << sw.step_sel;   // 1, 2, 4 or 8

    always_ff @(posedge clk)
    begin
        if (!rst_n)
            count <= '0;
        else if (step)
        begin
            if (sw.down)
                count <= count - delta;     // wraps modulo 2^16
            else
                count <= count + delta;
        end
    end

    assign led = count[3:0];

endmodule

`default_nettype wire

//--- input_sync.sv
`default_nettype none

// double flop synchronizer for board pins
// pins are active low, the inversion happens in front of the first stage
module input_sync
    import board_pkg::*;
#(
    parameter type data_t = key_t
)
(
    input  logic  clk,
    input  logic  rst_n,
    input  data_t pins,
    output data_t level
);

    data_t meta;    // first stage, may go metastable

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            meta  <= data_t'('0);
            level <= data_t'('0);                // everything released
        end
        else
        begin
            meta  <= data_t'(~pins);
            level <= meta;
        end
    end

endmodule

`default_nettype wire

//--- seven_seg_mux.sv
`default_nettype none

`include "board_config.svh"

// time-multiplexed driver for the seven-segment digits
module seven_seg_mux
    import board_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] value,
    output disp_t       disp
);

    localparam int W_DIV = ($clog2(`REFRESH_DIV) > 0) ? $clog2(`REFRESH_DIV) : 1;
    localparam int W_IDX = ($clog2(`W_DIGIT) > 0) ? $clog2(`W_DIGIT) : 1;

    // standard hex font, h stays dark
    function automatic seg_t hex_font(input logic [3:0] nibble);
        case (nibble)
            4'h0: hex_font = 8'b1111_1100;
            4'h1: hex_font = 8'b0110_0000;
            4'h2: hex_font = 8'b1101_1010;
            4'h3: hex_font = 8'b1111_0010;
            4'h4: hex_font = 8'b0110_0110;
            4'h5: hex_font = 8'b1011_0110;
            4'h6: hex_font = 8'b1011_1110;
            4'h7: hex_font = 8'b1110_0000;
            4'h8: hex_font = 8'b1111_1110;
            4'h9: hex_font = 8'b1111_0110;
            4'ha: hex_font = 8'b1110_1110;
            4'hb: hex_font = 8'b0011_1110;
            4'hc: hex_font = 8'b1001_1100;
            4'hd: hex_font = 8'b0111_1010;
            4'he: hex_font = 8'b1001_1110;
            default: hex_font = 8'b1000_1110;   // F
        endcase
    endfunction

    // ***********************************************************************
    // scan control
    // ***********************************************************************

    logic [W_DIV-1:0] div_cnt;
    logic [W_IDX-1:0] idx;
    logic [W_IDX-1:0] idx_nxt;
    logic             scan_step;
    logic [3:0]       nibble;

    assign scan_step = (div_cnt == W_DIV'(`REFRESH_DIV - 1));

    always_comb
    begin
        idx_nxt = idx;
        if (scan_step)
            idx_nxt = (idx == W_IDX'(`W_DIGIT - 1)) ? '0 : idx + W_IDX'(1);
    end

    assign nibble = value[4 * idx_nxt +: 4];   // nibble for the digit about to be lit

    // ***********************************************************************
    // output register, pattern and enable move together
    // ***********************************************************************

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            div_cnt    <= '0;
            idx        <= '0;
            disp.seg   <= '0;
            disp.digit <= `W_DIGIT'(1);         // digit 0 lit
        end
        else
        begin
            div_cnt    <= scan_step ? '0 : div_cnt + W_DIV'(1);
            idx        <= idx_nxt;
            disp.seg   <= hex_font(nibble);
            disp.digit <= `W_DIGIT'(1) << idx_nxt;
        end
    end

endmodule

`default_nettype wire

//--- slow_strobe_gen.sv
`default_nettype none

`include "board_config.svh"

// one-cycle enable every DIV clocks, stands in for a slow clock
module slow_strobe_gen
#(
    parameter int DIV = `SLOW_DIV
)
(
    input  logic clk,
    input  logic rst_n,
    output logic tick
);

    localparam int W_CNT = (DIV > 1) ? $clog2(DIV) : 1;

    logic [W_CNT-1:0] cnt;
    logic             wrap;

    assign wrap = (cnt == W_CNT'(DIV - 1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else
        begin
            cnt  <= wrap ? '0 : cnt + W_CNT'(1);
            tick <= wrap;                       // high for the wrap cycle only
        end
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
board_pkg.sv
input_sync.sv
slow_strobe_gen.sv
hex_counter_lab.sv
seven_seg_mux.sv
board_specific_top.sv
tb_board_properties.sv
tb_board.sv

//--- tb_board.sv
`default_nettype none

`include "board_config.svh"

module tb_board
    import board_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;   // cycles per wait

    logic                clk;
    logic                rst_n;
    logic [1:0]          key_pins;  // active low
    logic [3:0]          sw_pins;   // active low
    logic [3:0]          led_n;
    logic [7:0]          seg_bus;
    logic [`W_DIGIT-1:0] digit_en;

    int          n_errors;
    int          n_checks;
    bit          abort;             // stops the stimulus loop after a timeout
    logic [31:0] rng_state;
    logic [15:0] model;             // count as the testbench expects it

    board_specific_top i_dut
    (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .KEY      ( key_pins ),
        .SW       ( sw_pins  ),
        .LED      ( led_n    ),
        .HGFEDCBA ( seg_bus  ),
        .DIGIT    ( digit_en )
    );

    bind hex_counter_lab tb_board_properties #(.LAB_SIDE(1'b1)) i_lab_props
    (
        .clk       ( clk              ),
        .rst_n     ( rst_n            ),
        .count     ( count            ),
        .step_sel  ( sw.step_sel      ),
        .slow_tick ( slow_tick        ),
        .digit     ( `W_DIGIT'(1)     )
    );

    bind seven_seg_mux tb_board_properties #(.LAB_SIDE(1'b0)) i_disp_props
    (
        .clk       ( clk        ),
        .rst_n     ( rst_n      ),
        .count     ( value      ),
        .step_sel  ( 2'b00      ),
        .slow_tick ( 1'b0       ),
        .digit     ( disp.digit )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ***********************************************************************
    // helpers
    // ***********************************************************************

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y ^= y << 13;
        y ^= y >> 17;
        y ^= y << 5;
        return y;
    endfunction

    // count after one step with the given switches
    function automatic logic [15:0] next_count(input logic [15:0] c, input sw_t s);
        logic [15:0] d;
        d = 16'd1 << s.step_sel;
        return s.down ? c - d : c + d;
    endfunction

    // hex font as lit segment letters placed on the bus with a at bit 0
    function automatic logic [7:0] font_bus(input logic [3:0] nibble);
        string      s;
        logic [7:0] bus;
        int         pos;
        case (nibble)
            4'h0: s = "abcdef";
            4'h1: s = "bc";
            4'h2: s = "abdeg";
            4'h3: s = "abcdg";
            4'h4: s = "bcfg";
            4'h5: s = "acdfg";
            4'h6: s = "acdefg";
            4'h7: s = "abc";
            4'h8: s = "abcdefg";
            4'h9: s = "abcdfg";
            4'ha: s = "abcefg";
            4'hb: s = "cdefg";
            4'hc: s = "adef";
            4'hd: s = "bcdeg";
            4'he: s = "adefg";
            default: s = "aefg";
        endcase
        bus = '0;
        for (int i = 0; i < s.len(); i++)
        begin
            pos = int'(s[i]) - 97;      // letter a is 97
            bus[pos[2:0]] = 1'b1;
        end
        return bus;
    endfunction

    task automatic check(input logic [15:0] actual, input logic [15:0] expected,
                         input string what);
        n_checks++;
        if (actual !== expected)
        begin
            n_errors++;
            $display("[ERROR] %0d ns: %s, got %h, expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic timed_out(input string what);
        n_errors++;
        abort = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT);
    endtask

    task automatic set_switches(input sw_t s);
        @(posedge clk);
        sw_pins <= ~s;
    endtask

    task automatic wait_led(input logic [3:0] nibble);
        int t;
        t = 0;
        @(negedge clk);
        while (~led_n !== nibble && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (~led_n !== nibble)
            timed_out("expected LED value");
        else
            n_checks++;
    endtask

    task automatic wait_change(input logic [3:0] prev, output int n_cyc);
        n_cyc = 0;
        do
        begin
            @(negedge clk);
            n_cyc++;
        end
        while (led_n === prev && n_cyc < TIMEOUT);
        if (led_n === prev)
            timed_out("LED change in auto run");
    endtask

    task automatic wait_digit(input int idx);
        int t;
        t = 0;
        @(negedge clk);                 // skips the pattern left from reset
        while (digit_en !== (`W_DIGIT'(1) << idx) && t < TIMEOUT)
        begin
            @(negedge clk);
            t++;
        end
        if (digit_en !== (`W_DIGIT'(1) << idx))
            timed_out($sformatf("digit %0d enable", idx));
    endtask

    // ***********************************************************************
    // operations
    // ***********************************************************************

    task automatic press_step(input sw_t s, input logic [15:0] expected);
        key_t       k;
        logic [15:0] exp_cnt;
        exp_cnt = next_count(model, s);
        check(exp_cnt, expected, "stimulus file count after press");
        set_switches(s);
        repeat (3) @(posedge clk);      // switches settle through the sync
        k.step  = 1'b1;
        k.spare = 1'b0;
        key_pins <= ~k;
        repeat (3) @(posedge clk);
        key_pins <= '1;
        wait_led(exp_cnt[3:0]);
        model = exp_cnt;
        rng_state = xorshift32(rng_state);
        repeat (int'(rng_state[2:0]) + 1) @(posedge clk);   // release gap 1 to 8
    endtask

    task automatic auto_steps(input sw_t s, input logic [15:0] expected, input int n);
        sw_t        stop;
        logic [3:0] prev;
        logic [3:0] now;
        int         gap;
        bit         moved;
        set_switches(s);
        @(negedge clk);
        prev = led_n;
        for (int k = 1; k <= n && !abort; k++)
        begin
            wait_change(prev, gap);
            if (!abort)
            begin
                model = next_count(model, s);
                now   = ~led_n;
                check({12'd0, now}, {12'd0, model[3:0]}, "LED in auto run");
                if (k > 1)
                    check(16'(gap), 16'(`SLOW_DIV), "cycles between auto steps");
                prev = led_n;
            end
        end
        stop = s;
        stop.auto_run = 1'b0;
        set_switches(stop);
        moved = 1'b0;
        repeat (3 * `SLOW_DIV)
        begin
            @(negedge clk);
            if (led_n !== prev)
                moved = 1'b1;
        end
        check({15'd0, moved}, 16'd0, "LED moved after auto run cleared");
        check(model, expected, "count after auto run");
    endtask

    task automatic display_check(input logic [15:0] expected);
        for (int idx = 0; idx < `W_DIGIT && !abort; idx++)
        begin
            wait_digit(idx);
            if (!abort)
                check({8'd0, seg_bus}, {8'd0, font_bus(expected[4 * idx +: 4])},
                      $sformatf("segments of digit %0d", idx));
        end
    endtask

    // ***********************************************************************
    // main sequence
    // ***********************************************************************

    initial
    begin
        int          fd;
        string       line;
        logic [7:0]  op;
        logic [3:0]  sw_raw;
        logic [15:0] exp_cnt;
        int          n_chg;
        int          n_fields;
        int          n_assert;

        rst_n     = 1'b0;
        key_pins  = '1;                 // buttons released
        sw_pins   = '1;                 // switches off
        n_errors  = 0;
        n_checks  = 0;
        abort     = 1'b0;
        rng_state = 32'd81824;
        model     = '0;

        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check({12'd0, led_n}, 16'h000f, "LED after reset");
        check({12'd0, digit_en}, 16'h0001, "DIGIT after reset");

        fd = $fopen("board_stim.txt", "r");
        if (fd == 0)
        begin
            $display("could not open board_stim.txt");
            n_errors++;
            abort = 1'b1;
        end

        while (!abort && !$feof(fd))
        begin
            if ($fgets(line, fd) == 0)
                break;
            if (line.len() < 2 || line[0] == "#")
                continue;
            n_fields = $sscanf(line, "%c %h %h %d", op, sw_raw, exp_cnt, n_chg);
            if (n_fields != 4)
            begin
                $display("stimulus line could not be read: %s", line);
                n_errors++;
                continue;
            end
            case (op)
                "P": press_step(sw_t'(sw_raw), exp_cnt);
                "A": auto_steps(sw_t'(sw_raw), exp_cnt, n_chg);
                "D": display_check(exp_cnt);
                default:
                begin
                    $display("unknown operation in stimulus line: %s", line);
                    n_errors++;
                end
            endcase
        end
        if (fd != 0)
            $fclose(fd);

        n_assert = i_dut.i_lab.i_lab_props.n_fail + i_dut.i_seven_seg_mux.i_disp_props.n_fail;
        n_errors += n_assert;
        $display("checks %0d, errors %0d, assertion failures %0d", n_checks, n_errors, n_assert);
        if (n_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_board_properties.sv
`default_nettype none

`include "board_config.svh"

// concurrent checks, bound once into the lab core and once into the display driver
module tb_board_properties
#(
    parameter bit LAB_SIDE = 1'b1       // 1 for hex_counter_lab, 0 for seven_seg_mux
)
(
    input logic                 clk,
    input logic                 rst_n,
    input logic [15:0]          count,
    input logic [1:0]           step_sel,
    input logic                 slow_tick,
    input logic [`W_DIGIT-1:0]  digit
);

    timeunit 1ns;
    timeprecision 100ps;

    int          n_fail = 0;        // read by the testbench at the end of the run
    logic [15:0] delta;

    assign delta = 16'd1 << step_sel;

    if (LAB_SIDE)
    begin : g_lab
        // any change of the count is exactly one step up or down
        a_count_step: assert property (@(posedge clk) disable iff (!rst_n)
            (count != $past(count)) |->
                ((count - $past(count)) == $past(delta) ||
                 ($past(count) - count) == $past(delta)))
        else
        begin
            n_fail++;
            $error("count moved by more than one step");
        end

        a_tick_single: assert property (@(posedge clk) disable iff (!rst_n)
            slow_tick |=> !slow_tick)
        else
        begin
            n_fail++;
            $error("slow_tick high on two cycles in a row");
        end
    end
    else
    begin : g_disp
        a_digit_onehot: assert property (@(posedge clk) disable iff (!rst_n)
            $onehot(digit))
        else
        begin
            n_fail++;
            $error("digit enable is not one-hot");
        end
    end

endmodule

`default_nettype wire
